//--- common/prot_eng_pkg.sv
`default_nettype none

package prot_eng_pkg;

   // Stream word as carried on every ready/valid path
   typedef struct packed {
      logic [1:0]  occ;     // Valid bytes in last word, 0 means four
      logic        eof;
      logic        sof;
      logic [31:0] data;
   } pkt_word_t;

   // Data field of the first word of a frame
   typedef struct packed {
      logic [12:0] spare;
      logic [1:0]  port;    // Destination port, selects table slot
      logic        hdr_en;  // Prepend ETH/IP/UDP headers
      logic [15:0] length;  // Payload length in bytes
   } ctrl_word_t;

   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   localparam int unsigned HDR_WORDS        = 11;  // 4 ETH + 5 IP + 2 UDP
   localparam int unsigned IP_UDP_HDR_BYTES = 28;  // IP header plus UDP header
   localparam int unsigned UDP_HDR_BYTES    = 8;

endpackage

`default_nettype wire

//--- compile.f
common/prot_eng_pkg.sv
source/short_fifo.sv
prot_eng/header_table.sv
prot_eng/header_sequencer.sv
prot_eng/header_assembler.sv
prot_eng/prot_eng_tx.sv
verif/prot_eng_tx_tb.sv

//--- prot_eng/header_assembler.sv
`timescale 1ns/1ps
`default_nettype none

module header_assembler (
   input  wire                          clk,
   input  wire prot_eng_pkg::pkt_word_t in_word_i,
   input  wire [31:0]                   hdr_word_i,
   input  wire [15:0]                   csum_base_i,
   input  wire [15:0]                   length_i,
   input  wire [3:0]                    hdr_idx_i,
   input  wire                          hdr_phase_i,
   input  wire                          sof_i,
   input  wire                          csum_load_i,
   output prot_eng_pkg::pkt_word_t      out_word_o
);

   import prot_eng_pkg::*;

   logic [15:0] ip_length;
   logic [15:0] udp_length;
   logic [16:0] csum_raw;   // Before carry fold
   logic [15:0] csum_sum;
   logic [15:0] csum_q;
   logic [31:0] hdr_data;

   assign ip_length  = length_i + 16'(IP_UDP_HDR_BYTES);
   assign udp_length = length_i + 16'(UDP_HDR_BYTES);

   // Ones' complement add of pre-checksum and IP length
   assign csum_raw = {1'b0, csum_base_i} + {1'b0, ip_length};
   assign csum_sum = csum_raw[15:0] + {15'd0, csum_raw[16]};  // End-around carry

   always_ff @(posedge clk)
   begin
      if (csum_load_i)
      begin
         csum_q <= csum_sum;
      end
   end

   always_comb
   begin
      case (hdr_idx_i)
         4'd5:    hdr_data = {hdr_word_i[31:16], ip_length};   // IP total length
         4'd7:    hdr_data = {hdr_word_i[31:16], ~csum_q};     // IP header checksum
         4'd11:   hdr_data = {udp_length, hdr_word_i[15:0]};   // UDP length
         default: hdr_data = hdr_word_i;
      endcase
   end

   always_comb
   begin
      out_word_o.sof = sof_i;
      if (hdr_phase_i)
      begin
         out_word_o.data = hdr_data;
         out_word_o.eof  = 1'b0;
         out_word_o.occ  = 2'b00;
      end
      else
      begin
         out_word_o.data = in_word_i.data;
         out_word_o.eof  = in_word_i.eof;
         out_word_o.occ  = in_word_i.occ;
      end
   end

endmodule

`default_nettype wire

//--- prot_eng/header_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module header_sequencer (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          clear_i,
   input  wire prot_eng_pkg::pkt_word_t in_word_i,
   input  wire                          in_valid_i,
   output logic                         in_ready_o,
   output logic                         out_valid_o,
   input  wire                          out_ready_i,
   output logic [1:0]                   port_o,
   output logic [15:0]                  length_o,
   output logic [3:0]                   hdr_idx_o,
   output logic                         hdr_phase_o,
   output logic                         sof_o,
   output logic                         csum_load_o
);

   import prot_eng_pkg::*;

   localparam logic [3:0] S_IDLE    = 4'd0;
   localparam logic [3:0] S_LAST    = 4'(HDR_WORDS);      // UDP length word
   localparam logic [3:0] S_PAYLOAD = 4'(HDR_WORDS + 1);
   localparam logic [3:0] S_CSUM    = 4'd7;               // IP checksum word

   logic [3:0] state;   // 0 idle, 1..11 header steps, 12 payload
   logic       step;
   ctrl_word_t ctrl;

   assign ctrl = ctrl_word_t'(in_word_i.data);
   assign step = in_valid_i && out_ready_i;   // Header steps also wait for input

   assign hdr_idx_o   = state;
   assign hdr_phase_o = (state != S_IDLE) && (state != S_PAYLOAD);

   // Control word is swallowed, header steps leave the input untouched
   assign in_ready_o  = out_ready_i && ((state == S_IDLE) || (state == S_PAYLOAD));
   assign out_valid_o = in_valid_i && (state != S_IDLE);

   // Checksum register refreshed until the word that carries it
   assign csum_load_o = step && hdr_phase_o && (state < S_CSUM);

   always_ff @(posedge clk)
   begin
      if (reset || clear_i)
      begin
         state <= S_IDLE;
         sof_o <= 1'b0;
      end
      else if (step)
      begin
         case (state)
            S_IDLE:
            begin
               sof_o <= 1'b1;   // Next emitted word opens the frame
               state <= ctrl.hdr_en ? 4'd1 : S_PAYLOAD;
            end
            S_PAYLOAD:
            begin
               sof_o <= 1'b0;
               if (in_word_i.eof)
               begin
                  state <= S_IDLE;
               end
            end
            default:
            begin
               sof_o <= 1'b0;
               state <= (state == S_LAST) ? S_PAYLOAD : state + 4'd1;
            end
         endcase
      end
   end

   // Held for the whole frame
   always_ff @(posedge clk)
   begin
      if (step && (state == S_IDLE))
      begin
         port_o   <= ctrl.port;
         length_o <= ctrl.length;
      end
   end

endmodule

`default_nettype wire

//--- prot_eng/header_table.sv
`timescale 1ns/1ps
`default_nettype none

module header_table #(
   parameter logic [7:0] BASE = 8'h00
) (
   input  wire                         clk,
   input  wire prot_eng_pkg::set_bus_t set_i,
   input  wire [1:0][5:0]              rd_addr_i,
   output logic [1:0][31:0]            rd_data_o
);

   logic [31:0] hdr_mem [64];   // 16 words per port, port in index bits 5:4
   logic        wr_hit;

   // Top two address bits pick this engine's block
   assign wr_hit = set_i.stb && (set_i.addr[7:6] == BASE[7:6]);

   always_ff @(posedge clk)
   begin
      if (wr_hit)
      begin
         hdr_mem[set_i.addr[5:0]] <= set_i.data;
      end
   end

   // Read 0 follows the header step, read 1 fetches the port's word 0
   assign rd_data_o[0] = hdr_mem[rd_addr_i[0]];
   assign rd_data_o[1] = hdr_mem[rd_addr_i[1]];

endmodule

`default_nettype wire

//--- prot_eng/prot_eng_tx.sv
`timescale 1ns/1ps
`default_nettype none

module prot_eng_tx #(
   parameter logic [7:0] BASE    = 8'h00,
   parameter int         FIFO_AW = 4
) (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          clear_i,
   input  wire prot_eng_pkg::set_bus_t  set_i,
   input  wire prot_eng_pkg::pkt_word_t data_i,
   input  wire                          src_rdy_i,
   output logic                         dst_rdy_o,
   output prot_eng_pkg::pkt_word_t      data_o,
   output logic                         src_rdy_o,
   input  wire                          dst_rdy_i
);

   import prot_eng_pkg::*;

   pkt_word_t        in_word;
   logic             in_valid;
   logic             in_ready;
   pkt_word_t        out_word;
   logic             out_valid;
   logic             out_ready;
   logic [1:0]       port;
   logic [15:0]      length;
   logic [3:0]       hdr_idx;
   logic             hdr_phase;
   logic             sof;
   logic             csum_load;
   logic [1:0][5:0]  tbl_addr;
   logic [1:0][31:0] tbl_data;

   assign tbl_addr[0] = {port, hdr_idx};   // Current header word
   assign tbl_addr[1] = {port, 4'd0};      // Word 0 holds the pre-checksum

   // Input side buffer, keeps the engine from deadlocking
   short_fifo #(.FIFO_AW(FIFO_AW)) head_fifo (
      .clk(clk), .reset(reset), .clear_i(clear_i),
      .data_i(data_i), .src_rdy_i(src_rdy_i), .dst_rdy_o(dst_rdy_o),
      .data_o(in_word), .src_rdy_o(in_valid), .dst_rdy_i(in_ready)
   );

   header_table #(.BASE(BASE)) header_table_inst (
      .clk(clk), .set_i(set_i), .rd_addr_i(tbl_addr), .rd_data_o(tbl_data)
   );

   header_sequencer header_sequencer_inst (
      .clk(clk), .reset(reset), .clear_i(clear_i),
      .in_word_i(in_word), .in_valid_i(in_valid), .in_ready_o(in_ready),
      .out_valid_o(out_valid), .out_ready_i(out_ready),
      .port_o(port), .length_o(length), .hdr_idx_o(hdr_idx),
      .hdr_phase_o(hdr_phase), .sof_o(sof), .csum_load_o(csum_load)
   );

   header_assembler header_assembler_inst (
      .clk(clk), .in_word_i(in_word), .hdr_word_i(tbl_data[0]),
      .csum_base_i(tbl_data[1][15:0]), .length_i(length),
      .hdr_idx_i(hdr_idx), .hdr_phase_i(hdr_phase), .sof_i(sof),
      .csum_load_i(csum_load), .out_word_o(out_word)
   );

   short_fifo #(.FIFO_AW(FIFO_AW)) tail_fifo (
      .clk(clk), .reset(reset), .clear_i(clear_i),
      .data_i(out_word), .src_rdy_i(out_valid), .dst_rdy_o(out_ready),
      .data_o(data_o), .src_rdy_o(src_rdy_o), .dst_rdy_i(dst_rdy_i)
   );

endmodule

`default_nettype wire

//--- source/short_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module short_fifo #(
   parameter int FIFO_AW = 4
) (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          clear_i,
   input  wire prot_eng_pkg::pkt_word_t data_i,
   input  wire                          src_rdy_i,
   output logic                         dst_rdy_o,
   output prot_eng_pkg::pkt_word_t      data_o,
   output logic                         src_rdy_o,
   input  wire                          dst_rdy_i
);

   import prot_eng_pkg::*;

   localparam int DEPTH = 2 ** FIFO_AW;

   pkt_word_t          mem [DEPTH];
   logic [FIFO_AW-1:0] wr_ptr;
   logic [FIFO_AW-1:0] rd_ptr;
   logic [FIFO_AW:0]   count;   // Words held
   logic               push;
   logic               pop;

   assign dst_rdy_o = (count != (FIFO_AW + 1)'(DEPTH));  // Low only when full
   assign src_rdy_o = (count != '0);
   assign push      = src_rdy_i && dst_rdy_o;
   assign pop       = src_rdy_o && dst_rdy_i;
   assign data_o    = mem[rd_ptr];

   always_ff @(posedge clk)
   begin
      if (push)
      begin
         mem[wr_ptr] <= data_i;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset || clear_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
         begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // Idle or simultaneous push and pop
         endcase
      end
   end

endmodule

`default_nettype wire

//--- verif/prot_eng_tx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module prot_eng_tx_tb;

   import prot_eng_pkg::*;

   localparam logic [7:0] BASE_ADDR   = 8'h40;
   localparam int         TIMEOUT     = 2000;   // Cycles allowed for any single wait
   localparam int         SINK_ON     = 0;
   localparam int         SINK_RANDOM = 1;
   localparam int         SINK_OFF    = 2;

   logic        clk;
   logic        reset;
   logic        clear_i;
   set_bus_t    set_i;
   pkt_word_t   data_i;
   logic        src_rdy_i;
   logic        dst_rdy_o;
   pkt_word_t   data_o;
   logic        src_rdy_o;
   logic        dst_rdy_i;

   logic [31:0] ref_table [64];   // Model copy of the header templates
   pkt_word_t   payload_q [$];
   pkt_word_t   exp_q [$];
   pkt_word_t   exp_word;
   int          sink_mode;
   int          mode_now;
   int          n_words;
   int          n_errors;

   prot_eng_tx #(.BASE(BASE_ADDR), .FIFO_AW(4)) prot_eng_tx_inst (
      .clk(clk), .reset(reset), .clear_i(clear_i), .set_i(set_i),
      .data_i(data_i), .src_rdy_i(src_rdy_i), .dst_rdy_o(dst_rdy_o),
      .data_o(data_o), .src_rdy_o(src_rdy_o), .dst_rdy_i(dst_rdy_i)
   );

   always
   begin
      #2;
      clk = ~clk;
   end

   // Sink side ready, mode taken at the edge so changes land one cycle later
   always @(posedge clk)
   begin
      mode_now = sink_mode;
      #1;
      case (mode_now)
         SINK_RANDOM: dst_rdy_i = (($urandom % 3) != 0);
         SINK_OFF:    dst_rdy_i = 1'b0;
         default:     dst_rdy_i = 1'b1;
      endcase
   end

   // Expected words of one frame from the table copy, control word and payload
   function automatic void model_frame(input ctrl_word_t ctrl);
      logic [31:0] tmpl;
      logic [15:0] ip_len;
      logic [15:0] udp_len;
      logic [31:0] sum;
      pkt_word_t   w;
      int          base;
      base    = int'({ctrl.port, 4'h0});
      ip_len  = ctrl.length + 16'(IP_UDP_HDR_BYTES);
      udp_len = ctrl.length + 16'(UDP_HDR_BYTES);
      sum     = ref_table[base][15:0] + ip_len;   // Pre-checksum lives in word 0
      sum     = sum[15:0] + sum[31:16];           // Fold the carry back in
      if (ctrl.hdr_en)
      begin
         for (int k = 1; k <= HDR_WORDS; k++)
         begin
            tmpl = ref_table[base + k];
            if (k == 5)
               tmpl[15:0] = ip_len;
            else if (k == 7)
               tmpl[15:0] = ~sum[15:0];
            else if (k == 11)
               tmpl[31:16] = udp_len;
            w      = '0;
            w.data = tmpl;
            w.sof  = (k == 1);
            exp_q.push_back(w);
         end
      end
      foreach (payload_q[i])
      begin
         w     = payload_q[i];
         w.sof = !ctrl.hdr_en && (i == 0);   // Only the very first word opens the frame
         exp_q.push_back(w);
      end
   endfunction

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      set_i.stb  = 1'b1;
      set_i.addr = addr;
      set_i.data = data;
      if (addr[7:6] == BASE_ADDR[7:6])
      begin
         ref_table[addr[5:0]] = data;
      end
      @(posedge clk);
      #1;
      set_i.stb = 1'b0;
   endtask

   task automatic send_word(input pkt_word_t w, input bit gaps);
      int waited;
      bit taken;
      waited = 0;
      taken  = 1'b0;
      if (gaps && (($urandom % 4) == 0))
      begin
         repeat (1 + $urandom % 3)
         begin
            @(posedge clk);
            #1;
         end
      end
      data_i    = w;
      src_rdy_i = 1'b1;
      while (!taken && (waited < TIMEOUT))
      begin
         taken = dst_rdy_o;   // Ready is stable mid-cycle
         @(posedge clk);
         #1;
         waited++;
      end
      src_rdy_i = 1'b0;
      if (!taken)
      begin
         $display("Input word was never accepted by the engine");
         n_errors++;
      end
   endtask

   task automatic send_frame(input logic [1:0] port, input logic hdr_en,
                             input logic [15:0] length, input bit gaps);
      ctrl_word_t ctrl;
      pkt_word_t  w;
      int         n_payload;
      ctrl        = '0;
      ctrl.port   = port;
      ctrl.hdr_en = hdr_en;
      ctrl.length = length;
      n_payload   = (length + 3) / 4;
      payload_q.delete();
      for (int i = 0; i < n_payload; i++)
      begin
         w      = '0;
         w.data = $urandom;
         if (i == n_payload - 1)
         begin
            w.eof = 1'b1;
            w.occ = length[1:0];   // Zero means a full last word
         end
         payload_q.push_back(w);
      end
      model_frame(ctrl);
      w      = '0;
      w.sof  = 1'b1;
      w.data = ctrl;
      send_word(w, gaps);
      foreach (payload_q[i])
      begin
         send_word(payload_q[i], gaps);
      end
   endtask

   task automatic wait_drained();
      int waited;
      waited = 0;
      while ((exp_q.size() != 0) && (waited < TIMEOUT))
      begin
         @(posedge clk);
         #1;
         waited++;
      end
      if (exp_q.size() != 0)
      begin
         $display("Output stream stopped with %0d words still expected", exp_q.size());
         n_errors++;
      end
   endtask

   task automatic wait_output_valid();
      int waited;
      waited = 0;
      while (!src_rdy_o && (waited < TIMEOUT))
      begin
         @(posedge clk);
         #1;
         waited++;
      end
      if (!src_rdy_o)
      begin
         $display("Output never became valid before the clear");
         n_errors++;
      end
   endtask

   // Compare on every transfer, sampled mid-cycle before the edge that moves it
   always @(negedge clk)
   begin
      if (!reset && !clear_i && src_rdy_o && dst_rdy_i)
      begin
         if (exp_q.size() == 0)
         begin
            $display("Output word %h arrived when no word was expected", data_o);
            n_errors++;
         end
         else
         begin
            exp_word = exp_q.pop_front();
            n_words++;
            if (data_o.data !== exp_word.data)
            begin
               $display("Fail data_o.data: expected %h, got %h", exp_word.data, data_o.data);
               n_errors++;
            end
            if (data_o.sof !== exp_word.sof)
            begin
               $display("Fail data_o.sof: expected %h, got %h", exp_word.sof, data_o.sof);
               n_errors++;
            end
            if (data_o.eof !== exp_word.eof)
            begin
               $display("Fail data_o.eof: expected %h, got %h", exp_word.eof, data_o.eof);
               n_errors++;
            end
            if (data_o.occ !== exp_word.occ)
            begin
               $display("Fail data_o.occ: expected %h, got %h", exp_word.occ, data_o.occ);
               n_errors++;
            end
         end
      end
   end

   initial
   begin
      clk       = 1'b0;
      reset     = 1'b1;
      clear_i   = 1'b0;
      set_i     = '0;
      data_i    = '0;
      src_rdy_i = 1'b0;
      dst_rdy_i = 1'b0;
      sink_mode = SINK_ON;
      n_words   = 0;
      n_errors  = 0;
      void'($urandom(32'h5cf8_c46a));
      repeat (10) @(posedge clk);
      #1;
      reset = 1'b0;
      if (src_rdy_o !== 1'b0)
      begin
         $display("Fail src_rdy_o after reset: expected 0, got %h", src_rdy_o);
         n_errors++;
      end
      if (dst_rdy_o !== 1'b1)
      begin
         $display("Fail dst_rdy_o after reset: expected 1, got %h", dst_rdy_o);
         n_errors++;
      end

      for (int a = 0; a < 64; a++)
      begin
         write_setting(BASE_ADDR | 8'(a), $urandom);
      end
      write_setting(BASE_ADDR | 8'h00, {16'h4500, 16'h1c46});   // Port 0 pre-checksum
      write_setting(BASE_ADDR | 8'h10, {16'h4500, 16'h1234});
      write_setting(BASE_ADDR | 8'h20, {16'h4500, 16'h8000});
      write_setting(BASE_ADDR | 8'h30, {16'h4500, 16'hfff0});   // Sum carries out

      send_frame(2'd0, 1'b1, 16'd20, 1'b0);
      wait_drained();
      send_frame(2'd1, 1'b0, 16'd13, 1'b0);
      wait_drained();
      send_frame(2'd1, 1'b1, 16'd7, 1'b0);
      send_frame(2'd2, 1'b1, 16'd64, 1'b0);
      send_frame(2'd3, 1'b1, 16'd100, 1'b0);
      wait_drained();

      // Writes outside this engine's block must not land
      write_setting(8'h81, 32'hdead_beef);
      write_setting(8'hc5, 32'h0bad_f00d);
      write_setting(8'h00, 32'h1111_2222);
      send_frame(2'd0, 1'b1, 16'd9, 1'b0);
      wait_drained();

      sink_mode = SINK_RANDOM;
      repeat (40)
      begin
         send_frame(2'($urandom), 1'($urandom), 16'(1 + $urandom % 64), 1'b1);
      end
      wait_drained();

      // Stall the output partway through a frame, then clear
      sink_mode = SINK_OFF;
      repeat (2) @(posedge clk);
      #1;
      send_frame(2'd2, 1'b1, 16'd84, 1'b0);   // Fills the tail FIFO, then the head FIFO
      wait_output_valid();
      repeat (6) @(posedge clk);
      #1;
      if (dst_rdy_o !== 1'b0)
      begin
         $display("Fail dst_rdy_o under back-pressure: expected 0, got %h", dst_rdy_o);
         n_errors++;
      end
      clear_i = 1'b1;
      @(posedge clk);
      #1;
      clear_i = 1'b0;
      exp_q.delete();
      if (src_rdy_o !== 1'b0)
      begin
         $display("Fail src_rdy_o after clear: expected 0, got %h", src_rdy_o);
         n_errors++;
      end
      if (dst_rdy_o !== 1'b1)
      begin
         $display("Fail dst_rdy_o after clear: expected 1, got %h", dst_rdy_o);
         n_errors++;
      end
      sink_mode = SINK_ON;
      send_frame(2'd3, 1'b1, 16'd18, 1'b0);
      wait_drained();

      $display("Words checked: %0d, errors: %0d", n_words, n_errors);
      if (n_errors == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

`default_nettype wire
